//--- include/rast_config.svh
/*
 * coordinate and colour widths, FIFO depth, counter width
 * and the pixel limits of the test screen
 */
`ifndef RAST_CONFIG_SVH
`define RAST_CONFIG_SVH

// total bits of a fixed-point coordinate
`define RAST_SIGFIG 16
// fraction bits of a coordinate
`define RAST_RADIX 4
// bits per colour channel
`define RAST_COLOR_W 8
// boxed triangles held between box stage and iterator
`define RAST_FIFO_DEPTH 4
// triangle and hit counters
`define RAST_CNT_W 16
// test screen in whole pixels
`define RAST_SCREEN_W 32
`define RAST_SCREEN_H 32

`endif

//--- rast.f
+incdir+include
source/rast_pkg.sv
source/rast_bbox.sv
source/rast_tri_fifo.sv
source/rast_scan_iter.sv
source/rast_edge_test.sv
source/rast_top.sv
tb/rast_sva.sv
tb/rast_checker.sv
tb/rast_tb.sv

//--- source/rast_bbox.sv
/*
 * bounding box stage: vertex extents snapped inward to the pixel grid,
 * clipped to the screen, registered with the triangle, halt under full
 */
`timescale 1ns/100ps
`include "rast_config.svh"

module rast_bbox (
    input  logic             clk,
    input  logic             rst,
    input  logic             tri_valid,
    input  rast_pkg::coord_t x0,
    input  rast_pkg::coord_t y0,
    input  rast_pkg::coord_t x1,
    input  rast_pkg::coord_t y1,
    input  rast_pkg::coord_t x2,
    input  rast_pkg::coord_t y2,
    input  rast_pkg::color_t color_r,
    input  rast_pkg::color_t color_g,
    input  rast_pkg::color_t color_b,
    input  rast_pkg::coord_t screen_w,
    input  rast_pkg::coord_t screen_h,
    input  logic             full,
    output logic             halt,
    output logic             box_valid,
    output rast_pkg::coord_t bx0,
    output rast_pkg::coord_t by0,
    output rast_pkg::coord_t bx1,
    output rast_pkg::coord_t by1,
    output rast_pkg::coord_t bx2,
    output rast_pkg::coord_t by2,
    output rast_pkg::color_t box_r,
    output rast_pkg::color_t box_g,
    output rast_pkg::color_t box_b,
    output rast_pkg::coord_t box_x_lo,
    output rast_pkg::coord_t box_x_hi,
    output rast_pkg::coord_t box_y_lo,
    output rast_pkg::coord_t box_y_hi
);

    // fraction bits set, and one whole pixel
    localparam rast_pkg::coord_t FRAC_MASK = rast_pkg::coord_t'((1 << `RAST_RADIX) - 1);
    localparam rast_pkg::coord_t ONE_PIX = rast_pkg::coord_t'(1 << `RAST_RADIX);

    rast_pkg::coord_t min_x, max_x, min_y, max_y;
    rast_pkg::coord_t lo_x, hi_x, lo_y, hi_y;
    rast_pkg::coord_t lim_x, lim_y;
    rast_pkg::coord_t clip_x_lo, clip_x_hi, clip_y_lo, clip_y_hi;
    logic             empty;

    function automatic rast_pkg::coord_t min3(
        input rast_pkg::coord_t a, b, c);
        rast_pkg::coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic rast_pkg::coord_t max3(
        input rast_pkg::coord_t a, b, c);
        rast_pkg::coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // extents over the three vertices
    assign min_x = min3(x0, x1, x2);
    assign max_x = max3(x0, x1, x2);
    assign min_y = min3(y0, y1, y2);
    assign max_y = max3(y0, y1, y2);

    // low edge rounds up, high edge rounds down
    assign lo_x = (min_x + FRAC_MASK) & ~FRAC_MASK;
    assign lo_y = (min_y + FRAC_MASK) & ~FRAC_MASK;
    assign hi_x = max_x & ~FRAC_MASK;
    assign hi_y = max_y & ~FRAC_MASK;

    // last pixel on each axis
    assign lim_x = screen_w - ONE_PIX;
    assign lim_y = screen_h - ONE_PIX;

    // clamp into 0 .. screen-1
    assign clip_x_lo = (lo_x < 0) ? '0 : lo_x;
    assign clip_y_lo = (lo_y < 0) ? '0 : lo_y;
    assign clip_x_hi = (hi_x > lim_x) ? lim_x : hi_x;
    assign clip_y_hi = (hi_y > lim_y) ? lim_y : hi_y;

    // no sample left after rounding and clipping
    assign empty = (clip_x_lo > clip_x_hi) || (clip_y_lo > clip_y_hi);

    // stall while the FIFO refuses the held box
    assign halt = box_valid & full;

    always_ff @(posedge clk) begin
        if (rst) begin
            box_valid <= 1'b0;
        end else if (!halt) begin
            // empty boxes are accepted and dropped here
            box_valid <= tri_valid & ~empty;
        end
    end

    // triangle payload, held together with box_valid
    always_ff @(posedge clk) begin
        if (!halt) begin
            bx0      <= x0;
            by0      <= y0;
            bx1      <= x1;
            by1      <= y1;
            bx2      <= x2;
            by2      <= y2;
            box_r    <= color_r;
            box_g    <= color_g;
            box_b    <= color_b;
            box_x_lo <= clip_x_lo;
            box_x_hi <= clip_x_hi;
            box_y_lo <= clip_y_lo;
            box_y_hi <= clip_y_hi;
        end
    end

endmodule

//--- source/rast_edge_test.sv
/*
 * two-stage inside test: edge cross products registered first,
 * sign check and hit output second
 */
`timescale 1ns/100ps

module rast_edge_test (
    input  logic             clk,
    input  logic             rst,
    input  logic             samp_valid,
    input  rast_pkg::coord_t samp_x,
    input  rast_pkg::coord_t samp_y,
    input  rast_pkg::coord_t samp_x0,
    input  rast_pkg::coord_t samp_y0,
    input  rast_pkg::coord_t samp_x1,
    input  rast_pkg::coord_t samp_y1,
    input  rast_pkg::coord_t samp_x2,
    input  rast_pkg::coord_t samp_y2,
    input  rast_pkg::color_t samp_r,
    input  rast_pkg::color_t samp_g,
    input  rast_pkg::color_t samp_b,
    output logic             hit_valid,
    output rast_pkg::coord_t hit_x,
    output rast_pkg::coord_t hit_y,
    output rast_pkg::color_t hit_r,
    output rast_pkg::color_t hit_g,
    output rast_pkg::color_t hit_b
);

    logic             valid_s1;
    rast_pkg::edge_t  e0_s1, e1_s1, e2_s1;
    rast_pkg::coord_t x_s1, y_s1;
    rast_pkg::color_t r_s1, g_s1, b_s1;

    // (b - a) x (s - a), positive when s lies left of a->b
    function automatic rast_pkg::edge_t edge_cross(
        input rast_pkg::coord_t ax, ay, bx, by, sx, sy);
        rast_pkg::coord_t ex, ey, px, py;
        ex = bx - ax;
        ey = by - ay;
        px = sx - ax;
        py = sy - ay;
        return rast_pkg::edge_t'(ex) * rast_pkg::edge_t'(py)
             - rast_pkg::edge_t'(ey) * rast_pkg::edge_t'(px);
    endfunction

    // valid bits of both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1  <= 1'b0;
            hit_valid <= 1'b0;
        end else begin
            valid_s1  <= samp_valid;
            // on the edge counts as inside
            hit_valid <= valid_s1 && (e0_s1 >= 0) && (e1_s1 >= 0) && (e2_s1 >= 0);
        end
    end

    // stage one, three edges in parallel
    always_ff @(posedge clk) begin
        e0_s1 <= edge_cross(samp_x0, samp_y0, samp_x1, samp_y1, samp_x, samp_y);
        e1_s1 <= edge_cross(samp_x1, samp_y1, samp_x2, samp_y2, samp_x, samp_y);
        e2_s1 <= edge_cross(samp_x2, samp_y2, samp_x0, samp_y0, samp_x, samp_y);
        x_s1  <= samp_x;
        y_s1  <= samp_y;
        r_s1  <= samp_r;
        g_s1  <= samp_g;
        b_s1  <= samp_b;
    end

    // stage two, sample and colour ride along
    always_ff @(posedge clk) begin
        hit_x <= x_s1;
        hit_y <= y_s1;
        hit_r <= r_s1;
        hit_g <= g_s1;
        hit_b <= b_s1;
    end

endmodule

//--- source/rast_pkg.sv
/*
 * rasterizer types: fixed-point coordinate, colour channel,
 * edge cross product, counter and scan iterator states
 */
`include "rast_config.svh"

package rast_pkg;

    // signed fixed point, RAST_RADIX fraction bits
    typedef logic signed [`RAST_SIGFIG-1:0] coord_t;

    // one unsigned colour channel
    typedef logic [`RAST_COLOR_W-1:0] color_t;

    // product of two coordinates, twice the width
    typedef logic signed [2*`RAST_SIGFIG-1:0] edge_t;

    // triangle and hit counts
    typedef logic [`RAST_CNT_W-1:0] count_t;

    // scan iterator
    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        LAST
    } iter_state_t;

endpackage

//--- source/rast_scan_iter.sv
/*
 * scan iterator FSM: pops a boxed triangle and walks its box
 * one pixel per cycle, rows in rising y, x rising within a row
 */
`timescale 1ns/100ps
`include "rast_config.svh"

module rast_scan_iter (
    input  logic             clk,
    input  logic             rst,
    input  logic             tri_avail,
    input  rast_pkg::coord_t head_x0,
    input  rast_pkg::coord_t head_y0,
    input  rast_pkg::coord_t head_x1,
    input  rast_pkg::coord_t head_y1,
    input  rast_pkg::coord_t head_x2,
    input  rast_pkg::coord_t head_y2,
    input  rast_pkg::color_t head_r,
    input  rast_pkg::color_t head_g,
    input  rast_pkg::color_t head_b,
    input  rast_pkg::coord_t head_x_lo,
    input  rast_pkg::coord_t head_x_hi,
    input  rast_pkg::coord_t head_y_lo,
    input  rast_pkg::coord_t head_y_hi,
    output logic             pop,
    output logic             samp_valid,
    output rast_pkg::coord_t samp_x,
    output rast_pkg::coord_t samp_y,
    output rast_pkg::coord_t samp_x0,
    output rast_pkg::coord_t samp_y0,
    output rast_pkg::coord_t samp_x1,
    output rast_pkg::coord_t samp_y1,
    output rast_pkg::coord_t samp_x2,
    output rast_pkg::coord_t samp_y2,
    output rast_pkg::color_t samp_r,
    output rast_pkg::color_t samp_g,
    output rast_pkg::color_t samp_b
);

    localparam rast_pkg::coord_t ONE_PIX = rast_pkg::coord_t'(1 << `RAST_RADIX);

    rast_pkg::iter_state_t state;
    rast_pkg::coord_t      x_lo, x_hi, y_hi;
    rast_pkg::coord_t      next_x, next_y;
    logic                  row_end;
    logic                  next_last;
    logic                  head_single;

    // take a new triangle whenever not mid-box
    assign pop        = (state != rast_pkg::SCAN) && tri_avail;
    assign samp_valid = (state != rast_pkg::IDLE);

    // step right, or wrap to the start of the next row
    assign row_end     = (samp_x == x_hi);
    assign next_x      = row_end ? x_lo : samp_x + ONE_PIX;
    assign next_y      = row_end ? samp_y + ONE_PIX : samp_y;
    assign next_last   = (next_x == x_hi) && (next_y == y_hi);
    // one-pixel box goes straight to LAST
    assign head_single = (head_x_lo == head_x_hi) && (head_y_lo == head_y_hi);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rast_pkg::IDLE;
        end else if (pop) begin
            state <= head_single ? rast_pkg::LAST : rast_pkg::SCAN;
        end else if (state == rast_pkg::SCAN) begin
            state <= next_last ? rast_pkg::LAST : rast_pkg::SCAN;
        end else begin
            // LAST with nothing waiting, or still idle
            state <= rast_pkg::IDLE;
        end
    end

    // latch the head triangle, first sample at the box corner
    always_ff @(posedge clk) begin
        if (pop) begin
            samp_x  <= head_x_lo;
            samp_y  <= head_y_lo;
            x_lo    <= head_x_lo;
            x_hi    <= head_x_hi;
            y_hi    <= head_y_hi;
            samp_x0 <= head_x0;
            samp_y0 <= head_y0;
            samp_x1 <= head_x1;
            samp_y1 <= head_y1;
            samp_x2 <= head_x2;
            samp_y2 <= head_y2;
            samp_r  <= head_r;
            samp_g  <= head_g;
            samp_b  <= head_b;
        end else if (state == rast_pkg::SCAN) begin
            samp_x <= next_x;
            samp_y <= next_y;
        end
    end

endmodule

//--- source/rast_top.sv
/*
 * rasterizer top: box stage, triangle FIFO, scan iterator, edge test
 */
`timescale 1ns/100ps

module rast_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             tri_valid,
    input  rast_pkg::coord_t x0,
    input  rast_pkg::coord_t y0,
    input  rast_pkg::coord_t x1,
    input  rast_pkg::coord_t y1,
    input  rast_pkg::coord_t x2,
    input  rast_pkg::coord_t y2,
    input  rast_pkg::color_t color_r,
    input  rast_pkg::color_t color_g,
    input  rast_pkg::color_t color_b,
    input  rast_pkg::coord_t screen_w,
    input  rast_pkg::coord_t screen_h,
    output logic             halt,
    output logic             hit_valid,
    output rast_pkg::coord_t hit_x,
    output rast_pkg::coord_t hit_y,
    output rast_pkg::color_t hit_r,
    output rast_pkg::color_t hit_g,
    output rast_pkg::color_t hit_b
);

    // box stage to FIFO
    logic             box_valid;
    logic             full;
    rast_pkg::coord_t bx0, by0, bx1, by1, bx2, by2;
    rast_pkg::color_t box_r, box_g, box_b;
    rast_pkg::coord_t box_x_lo, box_x_hi, box_y_lo, box_y_hi;

    // FIFO head to iterator
    logic             tri_avail;
    logic             pop;
    rast_pkg::coord_t head_x0, head_y0, head_x1, head_y1, head_x2, head_y2;
    rast_pkg::color_t head_r, head_g, head_b;
    rast_pkg::coord_t head_x_lo, head_x_hi, head_y_lo, head_y_hi;

    // iterator to edge test
    logic             samp_valid;
    rast_pkg::coord_t samp_x, samp_y;
    rast_pkg::coord_t samp_x0, samp_y0, samp_x1, samp_y1, samp_x2, samp_y2;
    rast_pkg::color_t samp_r, samp_g, samp_b;

    // port names line up stage to stage
    rast_bbox u_bbox (.*);

    rast_tri_fifo u_fifo (.*);

    rast_scan_iter u_iter (.*);

    rast_edge_test u_edge (.*);

endmodule

//--- source/rast_tri_fifo.sv
/*
 * circular FIFO of boxed triangles with occupancy count,
 * full toward the box stage and tri_avail toward the iterator
 */
`timescale 1ns/100ps
`include "rast_config.svh"

module rast_tri_fifo #(
    // power of two, at least 2
    parameter int DEPTH = `RAST_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             box_valid,
    input  rast_pkg::coord_t bx0,
    input  rast_pkg::coord_t by0,
    input  rast_pkg::coord_t bx1,
    input  rast_pkg::coord_t by1,
    input  rast_pkg::coord_t bx2,
    input  rast_pkg::coord_t by2,
    input  rast_pkg::color_t box_r,
    input  rast_pkg::color_t box_g,
    input  rast_pkg::color_t box_b,
    input  rast_pkg::coord_t box_x_lo,
    input  rast_pkg::coord_t box_x_hi,
    input  rast_pkg::coord_t box_y_lo,
    input  rast_pkg::coord_t box_y_hi,
    output logic             full,
    output logic             tri_avail,
    output rast_pkg::coord_t head_x0,
    output rast_pkg::coord_t head_y0,
    output rast_pkg::coord_t head_x1,
    output rast_pkg::coord_t head_y1,
    output rast_pkg::coord_t head_x2,
    output rast_pkg::coord_t head_y2,
    output rast_pkg::color_t head_r,
    output rast_pkg::color_t head_g,
    output rast_pkg::color_t head_b,
    output rast_pkg::coord_t head_x_lo,
    output rast_pkg::coord_t head_x_hi,
    output rast_pkg::coord_t head_y_lo,
    output rast_pkg::coord_t head_y_hi,
    input  logic             pop
);

    // ten coordinates and three colour channels per entry
    localparam int EW = 10 * `RAST_SIGFIG + 3 * `RAST_COLOR_W;
    localparam int AW = $clog2(DEPTH);

    logic [EW-1:0] mem [DEPTH];
    logic [EW-1:0] wr_data;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign wr_data = {bx0, by0, bx1, by1, bx2, by2, box_r, box_g, box_b,
                      box_x_lo, box_x_hi, box_y_lo, box_y_hi};

    // head entry read straight from the array
    assign {head_x0, head_y0, head_x1, head_y1, head_x2, head_y2,
            head_r, head_g, head_b,
            head_x_lo, head_x_hi, head_y_lo, head_y_hi} = mem[rd_ptr];

    assign full      = (count == (AW+1)'(DEPTH));
    assign tri_avail = (count != '0);
    assign wr_en     = box_valid & ~full;
    assign rd_en     = pop & tri_avail;

    // pointers wrap naturally at DEPTH
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

//--- tb/rast_checker.sv
/*
 * hit checker: captures accepted triangles, builds the expected
 * hit queue from the box and edge rules, compares each hit
 */
`timescale 1ns/100ps
`include "rast_config.svh"

module rast_checker (
    input  logic             clk,
    input  logic             rst,
    input  logic             tri_valid,
    input  logic             halt,
    input  rast_pkg::coord_t x0,
    input  rast_pkg::coord_t y0,
    input  rast_pkg::coord_t x1,
    input  rast_pkg::coord_t y1,
    input  rast_pkg::coord_t x2,
    input  rast_pkg::coord_t y2,
    input  rast_pkg::color_t color_r,
    input  rast_pkg::color_t color_g,
    input  rast_pkg::color_t color_b,
    input  rast_pkg::coord_t screen_w,
    input  rast_pkg::coord_t screen_h,
    input  logic             hit_valid,
    input  rast_pkg::coord_t hit_x,
    input  rast_pkg::coord_t hit_y,
    input  rast_pkg::color_t hit_r,
    input  rast_pkg::color_t hit_g,
    input  rast_pkg::color_t hit_b,
    input  logic             flush,
    output int               pending,
    output int               hits_seen,
    output int               errors
);

    localparam int R  = `RAST_RADIX;
    localparam int HW = 2 * `RAST_SIGFIG + 3 * `RAST_COLOR_W;

    // expected hits as {x, y, r, g, b}
    logic [HW-1:0]    exp_q[$];
    rast_pkg::coord_t ex, ey;
    rast_pkg::color_t er, eg, eb;

    // which side of a->b the sample sits on
    function automatic longint edge_side(input int ax, ay, bx, by, sx, sy);
        return longint'(bx - ax) * longint'(sy - ay) - longint'(by - ay) * longint'(sx - ax);
    endfunction

    // reference inside test, edges count as inside
    function automatic logic inside_tri(input int ax, ay, bx, by, cx, cy, sx, sy);
        return edge_side(ax, ay, bx, by, sx, sy) >= 0 &&
               edge_side(bx, by, cx, cy, sx, sy) >= 0 &&
               edge_side(cx, cy, ax, ay, sx, sy) >= 0;
    endfunction

    function automatic int lowest(input int a, b, c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int highest(input int a, b, c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // whole-pixel grid covered by the triangle, clipped to screen
    task automatic expect_tri(input int ax, ay, bx, by, cx, cy, sw, sh,
                              input rast_pkg::color_t r, g, b);
        int x_lo, x_hi, y_lo, y_hi, px, py;
        x_lo = -((-lowest(ax, bx, cx)) >>> R);
        y_lo = -((-lowest(ay, by, cy)) >>> R);
        x_hi = highest(ax, bx, cx) >>> R;
        y_hi = highest(ay, by, cy) >>> R;
        if (x_lo < 0) x_lo = 0;
        if (y_lo < 0) y_lo = 0;
        if (x_hi > sw - 1) x_hi = sw - 1;
        if (y_hi > sh - 1) y_hi = sh - 1;
        for (py = y_lo; py <= y_hi; py++) begin
            for (px = x_lo; px <= x_hi; px++) begin
                if (inside_tri(ax, ay, bx, by, cx, cy, px <<< R, py <<< R)) begin
                    exp_q.push_back({rast_pkg::coord_t'(px <<< R),
                                     rast_pkg::coord_t'(py <<< R), r, g, b});
                end
            end
        end
    endtask

    task automatic compare_field(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("Fail %0t %s expected %0d got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            hits_seen = 0;
            errors    = 0;
        end else begin
            // accepted this edge
            if (tri_valid && !halt) begin
                expect_tri(int'(x0), int'(y0), int'(x1), int'(y1), int'(x2), int'(y2),
                           int'(screen_w) >>> R, int'(screen_h) >>> R,
                           color_r, color_g, color_b);
            end
            if (hit_valid) begin
                hits_seen++;
                if (exp_q.size() == 0) begin
                    $display("unexpected hit at %0t on x %0d y %0d, none was expected",
                             $time, hit_x, hit_y);
                    errors++;
                end else begin
                    {ex, ey, er, eg, eb} = exp_q.pop_front();
                    compare_field("hit_x", int'(ex), int'(hit_x));
                    compare_field("hit_y", int'(ey), int'(hit_y));
                    compare_field("hit_r", int'(er), int'(hit_r));
                    compare_field("hit_g", int'(eg), int'(hit_g));
                    compare_field("hit_b", int'(eb), int'(hit_b));
                end
            end
            // leftovers after a drain timeout
            if (flush && exp_q.size() != 0) begin
                $display("%0d expected hits never arrived", exp_q.size());
                errors += exp_q.size();
                exp_q.delete();
            end
        end
        pending = exp_q.size();
    end

endmodule

//--- tb/rast_sva.sv
/*
 * concurrent assertions on reset values, source hold under halt
 * and the quiet hit output right after reset
 */
`timescale 1ns/100ps

module rast_sva (
    input logic             clk,
    input logic             rst,
    input logic             tri_valid,
    input logic             halt,
    input logic             box_valid,
    input logic             hit_valid,
    input rast_pkg::coord_t x0,
    input rast_pkg::coord_t y0,
    input rast_pkg::coord_t x1,
    input rast_pkg::coord_t y1,
    input rast_pkg::coord_t x2,
    input rast_pkg::coord_t y2,
    input rast_pkg::color_t color_r,
    input rast_pkg::color_t color_g,
    input rast_pkg::color_t color_b
);

    // failed assertions so far
    int fail_count;

    initial begin
        fail_count = 0;
    end

    // outputs cleared one cycle into reset
    reset_clears: assert property (@(posedge clk)
        rst |=> !halt && !box_valid && !hit_valid)
        else begin
            $error("halt, box_valid or hit_valid high after reset");
            fail_count++;
        end

    // source keeps its triangle while stalled
    source_holds: assert property (@(posedge clk) disable iff (rst)
        (tri_valid && halt) |=> tri_valid &&
            $stable({x0, y0, x1, y1, x2, y2, color_r, color_g, color_b}))
        else begin
            $error("triangle inputs changed while halt was high");
            fail_count++;
        end

    // nothing reaches the hit port this early
    no_early_hit: assert property (@(posedge clk)
        $fell(rst) |-> !hit_valid ##1 !hit_valid)
        else begin
            $error("hit_valid high within two cycles of reset release");
            fail_count++;
        end

endmodule

bind rast_top rast_sva u_sva (.*);

//--- tb/rast_tb.sv
/*
 * rasterizer testbench with clock, reset and falling-edge triangle source,
 * directed and random tests, drain wait, watchdog and final verdict
 */
`timescale 1ns/100ps
`include "rast_config.svh"

module rast_tb;

    localparam int R = `RAST_RADIX;
    // every triangle sent over all tests
    localparam int N_TRI = 47;
    localparam longint WD_NS = longint'(N_TRI) * (1024 + 20) * 10;

    logic             clk, rst, tri_valid, halt, hit_valid, flush;
    rast_pkg::coord_t x0, y0, x1, y1, x2, y2;
    rast_pkg::coord_t screen_w, screen_h, hit_x, hit_y;
    rast_pkg::color_t color_r, color_g, color_b, hit_r, hit_g, hit_b;
    int               pending, hits_seen, errors;
    int               tb_errs, base_hits, base_errs, tests_run, i, cx, cy, span;
    integer           seed;

    rast_top dut (.*);

    rast_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog
    initial begin
        #(WD_NS);
        $display("watchdog: run still going after %0d ns", WD_NS);
        $display("test failed");
        $finish;
    end

    // whole pixels plus sixteenths
    function automatic int fx(input int whole, input int frac);
        return whole * (1 << R) + frac;
    endfunction

    function automatic int rand_in(input int lo, input int hi);
        logic [31:0] u;
        u = $random(seed);
        return lo + int'(u % (hi - lo + 1));
    endfunction

    // hit mismatches, drain timeouts and failed assertions together
    function automatic int total_errors();
        return errors + tb_errs + dut.u_sva.fail_count;
    endfunction

    // starts at a falling edge and returns at the one after acceptance
    task automatic send_tri(input int ax, ay, bx, by, qx, qy, input int r, g, b);
        tri_valid = 1'b1;
        x0        = rast_pkg::coord_t'(ax);
        y0        = rast_pkg::coord_t'(ay);
        x1        = rast_pkg::coord_t'(bx);
        y1        = rast_pkg::coord_t'(by);
        x2        = rast_pkg::coord_t'(qx);
        y2        = rast_pkg::coord_t'(qy);
        color_r   = rast_pkg::color_t'(r);
        color_g   = rast_pkg::color_t'(g);
        color_b   = rast_pkg::color_t'(b);
        // halt seen here holds until the next rising edge
        while (halt) @(negedge clk);
        @(negedge clk);
        tri_valid = 1'b0;
    endtask

    // wait for an empty pipeline and report the test
    task automatic finish_test(input string name, input int ntri);
        int quiet;
        int waited;
        int limit;
        quiet  = 0;
        waited = 0;
        limit  = ntri * (1024 + 20);
        while (quiet < 3 && waited < limit) begin
            @(negedge clk);
            waited++;
            if (pending == 0 && !dut.box_valid && !dut.tri_avail &&
                !dut.samp_valid && !hit_valid) begin
                quiet++;
            end else begin
                quiet = 0;
            end
        end
        if (quiet < 3) begin
            $display("%s: pipeline did not drain within %0d cycles", name, limit);
            tb_errs++;
            flush = 1'b1;
            @(negedge clk);
            flush = 1'b0;
            @(negedge clk);
        end
        $display("%s: %0d hits, %0d errors", name, hits_seen - base_hits,
                 total_errors() - base_errs);
        base_hits = hits_seen;
        base_errs = total_errors();
        tests_run++;
    endtask

    initial begin
        seed      = 32'h92ff_99f1;
        rst       = 1'b1;
        tri_valid = 1'b0;
        flush     = 1'b0;
        {x0, y0, x1, y1, x2, y2} = '0;
        {color_r, color_g, color_b} = '0;
        screen_w  = rast_pkg::coord_t'(fx(`RAST_SCREEN_W, 0));
        screen_h  = rast_pkg::coord_t'(fx(`RAST_SCREEN_H, 0));
        tb_errs   = 0;
        base_hits = 0;
        base_errs = 0;
        tests_run = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        send_tri(fx(4, 0), fx(4, 0), fx(20, 8), fx(6, 0), fx(8, 0), fx(22, 4), 'h20, 'h80, 'hc0);
        finish_test("test 1 single ccw triangle", 1);

        // partly off on every side and then wholly left of the screen
        send_tri(fx(-7, 8), fx(-3, 0), fx(40, 0), fx(10, 0), fx(5, 0), fx(45, 0),
                 'h11, 'h22, 'h33);
        send_tri(fx(-20, 0), fx(-10, 0), fx(-5, 0), fx(-10, 0), fx(-10, 0), fx(-2, 0),
                 'hff, 0, 0);
        finish_test("test 2 screen clipping", 2);

        // one triangle clockwise and then counter-clockwise
        send_tri(fx(3, 0), fx(3, 0), fx(10, 0), fx(28, 0), fx(25, 0), fx(5, 0), 'h40, 'h50, 'h60);
        send_tri(fx(3, 0), fx(3, 0), fx(25, 0), fx(5, 0), fx(10, 0), fx(28, 0), 'h41, 'h51, 'h61);
        finish_test("test 3 winding", 2);

        // whole-pixel vertices put samples on edges and corners
        send_tri(fx(2, 0), fx(2, 0), fx(14, 0), fx(2, 0), fx(2, 0), fx(14, 0), 'h0a, 'h0b, 'h0c);
        send_tri(fx(30, 0), fx(30, 0), fx(18, 0), fx(30, 0), fx(30, 0), fx(18, 0),
                 'h0d, 'h0e, 'h0f);
        finish_test("test 4 edge samples", 2);

        // back to back with every third one large
        for (i = 0; i < 40; i++) begin
            span = (i % 3 == 0) ? 24 : 4;
            cx   = rand_in(-4, 35);
            cy   = rand_in(-4, 35);
            send_tri(fx(cx, 0) + rand_in(-span * 16, span * 16),
                     fx(cy, 0) + rand_in(-span * 16, span * 16),
                     fx(cx, 0) + rand_in(-span * 16, span * 16),
                     fx(cy, 0) + rand_in(-span * 16, span * 16),
                     fx(cx, 0) + rand_in(-span * 16, span * 16),
                     fx(cy, 0) + rand_in(-span * 16, span * 16),
                     rand_in(0, 255), rand_in(0, 255), rand_in(0, 255));
        end
        finish_test("test 5 random burst", 40);

        $display("tests %0d, hits %0d, errors %0d", tests_run, hits_seen, total_errors());
        if (total_errors() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
